// File: common/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// datapath word width
`define PIPE_WORD_W 16

// architectural registers, r0 is a normal register
`define PIPE_NUM_REGS 8

// data memory words, address wraps modulo depth
`define PIPE_DMEM_DEPTH 64

`endif

// File: common/pipe_pkg.sv
`default_nettype none
`include "pipe_defines.svh"

package pipe_pkg;

    typedef logic [`PIPE_WORD_W-1:0] word_t; // data word
    typedef logic [$clog2(`PIPE_NUM_REGS)-1:0] reg_idx_t; // register index

    // decoded operations, decode happens upstream of this pipeline
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,  // rs - rt
        OP_XOR  = 4'd3,
        OP_ANDN = 4'd4,  // rs & ~rt
        OP_ADDI = 4'd5,
        OP_SEQ  = 4'd6,
        OP_SLT  = 4'd7,  // signed compare
        OP_LBI  = 4'd8,
        OP_SLBI = 4'd9,
        OP_LD   = 4'd10, // address is rt + imm
        OP_ST   = 4'd11  // data is rs
    } op_e;

    // write-back source, same codes as the older processor core
    typedef enum logic [2:0] {
        SEL_ALU  = 3'd0,
        SEL_MEM  = 3'd1,
        SEL_PC   = 3'd2, // pc increment, not produced here
        SEL_SET  = 3'd3,
        SEL_LBI  = 3'd4,
        SEL_SLBI = 3'd5
    } wr_sel_e;

endpackage

`default_nettype wire

// File: hw/operand_fetch/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module operand_fetch (
    input  wire                 clk,
    input  wire                 rst,
    // decoded operation in
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire pipe_pkg::op_e  in_op,
    input  wire pipe_pkg::reg_idx_t in_rd,
    input  wire pipe_pkg::reg_idx_t in_rs,
    input  wire pipe_pkg::reg_idx_t in_rt,
    input  wire pipe_pkg::word_t in_imm, // already sign extended
    // write-back port
    input  wire                 memwb_reg_wr,
    input  wire pipe_pkg::reg_idx_t memwb_rd,
    input  wire pipe_pkg::word_t wb_data,
    // ID/EX register
    output logic                idex_valid,
    output pipe_pkg::op_e       idex_op,
    output pipe_pkg::reg_idx_t  idex_rd,
    output pipe_pkg::reg_idx_t  idex_rs,
    output pipe_pkg::reg_idx_t  idex_rt,
    output logic                idex_has_rt,
    output pipe_pkg::word_t     idex_imm,
    output pipe_pkg::wr_sel_e   idex_wr_sel,
    output logic                idex_reg_wr,
    output pipe_pkg::word_t     idex_rs_val,
    output pipe_pkg::word_t     idex_rt_val
);

    pipe_pkg::word_t rf [`PIPE_NUM_REGS]; // register file
    pipe_pkg::word_t rs_val;
    pipe_pkg::word_t rt_val;
    pipe_pkg::wr_sel_e wr_sel;
    logic has_rt;   // op reads rt
    logic reads_rs; // op reads rs
    logic reg_wr;   // op writes rd
    logic hazard;   // load-use, insert one bubble
    logic accept;

    // operand usage and write-back kind per op
    always_comb begin
        has_rt   = 1'b0;
        reads_rs = 1'b0;
        reg_wr   = 1'b1;
        wr_sel   = pipe_pkg::SEL_ALU;
        case (in_op)
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_XOR, pipe_pkg::OP_ANDN: begin
                has_rt   = 1'b1;
                reads_rs = 1'b1;
            end
            pipe_pkg::OP_ADDI: reads_rs = 1'b1;
            pipe_pkg::OP_SEQ, pipe_pkg::OP_SLT: begin
                has_rt   = 1'b1;
                reads_rs = 1'b1;
                wr_sel   = pipe_pkg::SEL_SET;
            end
            pipe_pkg::OP_LBI: wr_sel = pipe_pkg::SEL_LBI; // no source regs
            pipe_pkg::OP_SLBI: begin
                reads_rs = 1'b1;
                wr_sel   = pipe_pkg::SEL_SLBI;
            end
            pipe_pkg::OP_LD: begin
                has_rt = 1'b1; // address base
                wr_sel = pipe_pkg::SEL_MEM;
            end
            pipe_pkg::OP_ST: begin
                has_rt   = 1'b1;
                reads_rs = 1'b1; // store data
                reg_wr   = 1'b0;
            end
            default: reg_wr = 1'b0; // nop
        endcase
    end

    // a load in ID/EX has no result until MEM/WB, so a reader waits a cycle.
    // store data is exempt since mem_stage picks it up from the load later
    assign hazard = in_valid && idex_valid && (idex_op == pipe_pkg::OP_LD) &&
                    ((reads_rs && (in_op != pipe_pkg::OP_ST) && (in_rs == idex_rd)) ||
                     (has_rt && (in_rt == idex_rd)));
    assign in_ready = ~hazard; // op is held upstream
    assign accept   = in_valid & in_ready;

    // write-through so an op reading in the write-back cycle sees the new value
    assign rs_val = (memwb_reg_wr && (memwb_rd == in_rs)) ? wb_data : rf[in_rs];
    assign rt_val = (memwb_reg_wr && (memwb_rd == in_rt)) ? wb_data : rf[in_rt];

    always_ff @(posedge clk) begin
        if (memwb_reg_wr) begin
            rf[memwb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idex_valid  <= 1'b0;
            idex_reg_wr <= 1'b0;
            idex_op     <= pipe_pkg::OP_NOP;
        end else begin
            idex_valid  <= accept; // bubble when nothing accepted
            idex_reg_wr <= accept & reg_wr;
            idex_op     <= accept ? in_op : pipe_pkg::OP_NOP;
        end
    end

    // payload, only meaningful while idex_valid
    always_ff @(posedge clk) begin
        idex_rd     <= in_rd;
        idex_rs     <= in_rs;
        idex_rt     <= in_rt;
        idex_has_rt <= has_rt;
        idex_imm    <= in_imm;
        idex_wr_sel <= wr_sel;
        idex_rs_val <= rs_val;
        idex_rt_val <= rt_val;
    end

endmodule

`default_nettype wire

// File: hw/forward/forward.sv
`timescale 1ns/1ps
`default_nettype none

module forward (
    // ID/EX sources
    input  wire pipe_pkg::reg_idx_t idex_rs,
    input  wire pipe_pkg::reg_idx_t idex_rt,
    input  wire                 idex_has_rt,
    // EX/MEM stage
    input  wire                 exmem_reg_wr,
    input  wire pipe_pkg::reg_idx_t exmem_rd,
    input  wire pipe_pkg::reg_idx_t exmem_rs,
    input  wire pipe_pkg::op_e  exmem_op,
    input  wire pipe_pkg::wr_sel_e exmem_wr_sel,
    input  wire pipe_pkg::word_t exmem_alu_result,
    input  wire pipe_pkg::word_t exmem_set_result,
    input  wire pipe_pkg::word_t exmem_lbi_result,
    input  wire pipe_pkg::word_t exmem_slbi_result,
    // MEM/WB stage
    input  wire                 memwb_reg_wr,
    input  wire pipe_pkg::reg_idx_t memwb_rd,
    input  wire                 memwb_is_load,
    input  wire pipe_pkg::wr_sel_e memwb_wr_sel,
    input  wire pipe_pkg::word_t memwb_alu_result,
    input  wire pipe_pkg::word_t memwb_mem_result,
    input  wire pipe_pkg::word_t memwb_set_result,
    input  wire pipe_pkg::word_t memwb_lbi_result,
    input  wire pipe_pkg::word_t memwb_slbi_result,
    // selects and values
    output logic                ex_fwd_rs,      // EX/MEM to EX
    output logic                ex_fwd_rt,
    output logic                mem_fwd_rs,     // MEM/WB to EX
    output logic                mem_fwd_rt,
    output logic                mem_to_mem_fwd, // MEM/WB load to store data
    output pipe_pkg::word_t     ex_fwd_data,
    output pipe_pkg::word_t     mem_fwd_data,
    output pipe_pkg::word_t     wb_data
);

    // pick the result a stage will write back
    function automatic pipe_pkg::word_t sel_result(
        input pipe_pkg::wr_sel_e sel,
        input pipe_pkg::word_t   alu,
        input pipe_pkg::word_t   mem,
        input pipe_pkg::word_t   set,
        input pipe_pkg::word_t   lbi,
        input pipe_pkg::word_t   slbi
    );
        case (sel)
            pipe_pkg::SEL_ALU:  return alu;
            pipe_pkg::SEL_MEM:  return mem;
            pipe_pkg::SEL_PC:   return '0; // no pc increment results here
            pipe_pkg::SEL_SET:  return set;
            pipe_pkg::SEL_LBI:  return lbi;
            pipe_pkg::SEL_SLBI: return slbi;
            default:            return '0; // codes 6 and 7
        endcase
    endfunction

    // older stage writes a reg that the ID/EX op reads
    assign ex_fwd_rs = exmem_reg_wr && (exmem_rd == idex_rs);
    assign ex_fwd_rt = exmem_reg_wr && idex_has_rt && (exmem_rd == idex_rt);

    // EX/MEM is younger than MEM/WB so it wins when both match
    assign mem_fwd_rs = memwb_reg_wr && (memwb_rd == idex_rs) && !ex_fwd_rs;
    assign mem_fwd_rt = memwb_reg_wr && idex_has_rt && (memwb_rd == idex_rt) && !ex_fwd_rt;

    // store right behind a load of its data register
    assign mem_to_mem_fwd = memwb_is_load && (exmem_op == pipe_pkg::OP_ST) &&
                            (memwb_rd == exmem_rs);

    // load data does not exist yet in EX/MEM, hence zero for the mem slot
    assign ex_fwd_data = sel_result(exmem_wr_sel, exmem_alu_result, '0,
                                    exmem_set_result, exmem_lbi_result, exmem_slbi_result);

    assign mem_fwd_data = sel_result(memwb_wr_sel, memwb_alu_result, memwb_mem_result,
                                     memwb_set_result, memwb_lbi_result, memwb_slbi_result);
    assign wb_data = mem_fwd_data; // same value feeds the register file

endmodule

`default_nettype wire

// File: hw/execute/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                 clk,
    input  wire                 rst,
    // ID/EX register
    input  wire                 idex_valid,
    input  wire pipe_pkg::op_e  idex_op,
    input  wire pipe_pkg::reg_idx_t idex_rd,
    input  wire pipe_pkg::reg_idx_t idex_rs,
    input  wire                 idex_has_rt,
    input  wire pipe_pkg::word_t idex_imm,
    input  wire pipe_pkg::wr_sel_e idex_wr_sel,
    input  wire                 idex_reg_wr,
    input  wire pipe_pkg::word_t idex_rs_val,
    input  wire pipe_pkg::word_t idex_rt_val,
    // forwarding
    input  wire                 ex_fwd_rs,
    input  wire                 ex_fwd_rt,
    input  wire                 mem_fwd_rs,
    input  wire                 mem_fwd_rt,
    input  wire pipe_pkg::word_t ex_fwd_data,
    input  wire pipe_pkg::word_t mem_fwd_data,
    // EX/MEM register
    output logic                exmem_valid,
    output pipe_pkg::op_e       exmem_op,
    output pipe_pkg::reg_idx_t  exmem_rd,
    output pipe_pkg::reg_idx_t  exmem_rs,
    output logic                exmem_reg_wr,
    output pipe_pkg::wr_sel_e   exmem_wr_sel,
    output pipe_pkg::word_t     exmem_alu_result,
    output pipe_pkg::word_t     exmem_set_result,
    output pipe_pkg::word_t     exmem_lbi_result,
    output pipe_pkg::word_t     exmem_slbi_result,
    output pipe_pkg::word_t     exmem_store_data
);

    pipe_pkg::word_t rs_op; // true operands
    pipe_pkg::word_t rt_op;
    pipe_pkg::word_t alu;
    logic set_bit;

    // newest value wins, register file value last
    assign rs_op = ex_fwd_rs  ? ex_fwd_data  :
                   mem_fwd_rs ? mem_fwd_data : idex_rs_val;
    // rt held at zero for ops that do not read it
    assign rt_op = !idex_has_rt ? '0          :
                   ex_fwd_rt    ? ex_fwd_data :
                   mem_fwd_rt   ? mem_fwd_data : idex_rt_val;

    always_comb begin
        case (idex_op)
            pipe_pkg::OP_ADD:  alu = rs_op + rt_op;
            pipe_pkg::OP_SUB:  alu = rs_op - rt_op;
            pipe_pkg::OP_XOR:  alu = rs_op ^ rt_op;
            pipe_pkg::OP_ANDN: alu = rs_op & ~rt_op;
            pipe_pkg::OP_ADDI: alu = rs_op + idex_imm;
            pipe_pkg::OP_LD, pipe_pkg::OP_ST: alu = rt_op + idex_imm; // address
            default:           alu = '0;
        endcase
    end

    always_comb begin
        case (idex_op)
            pipe_pkg::OP_SEQ: set_bit = (rs_op == rt_op);
            pipe_pkg::OP_SLT: set_bit = ($signed(rs_op) < $signed(rt_op));
            default:          set_bit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exmem_valid  <= 1'b0;
            exmem_op     <= pipe_pkg::OP_NOP;
            exmem_reg_wr <= 1'b0;
            exmem_wr_sel <= pipe_pkg::SEL_ALU;
        end else begin
            exmem_valid  <= idex_valid;
            exmem_op     <= idex_op;
            exmem_reg_wr <= idex_reg_wr; // already clear for bubbles
            exmem_wr_sel <= idex_wr_sel;
        end
    end

    always_ff @(posedge clk) begin
        exmem_rd          <= idex_rd;
        exmem_rs          <= idex_rs; // for memory-to-memory compare
        exmem_alu_result  <= alu;
        exmem_set_result  <= {{($bits(pipe_pkg::word_t)-1){1'b0}}, set_bit};
        exmem_lbi_result  <= idex_imm;
        exmem_slbi_result <= {rs_op[7:0], idex_imm[7:0]}; // rs << 8 | imm low byte
        exmem_store_data  <= rs_op; // may still be stale behind a load
    end

endmodule

`default_nettype wire

// File: hw/mem_stage/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module mem_stage (
    input  wire                 clk,
    input  wire                 rst,
    // EX/MEM register
    input  wire                 exmem_valid,
    input  wire pipe_pkg::op_e  exmem_op,
    input  wire pipe_pkg::reg_idx_t exmem_rd,
    input  wire                 exmem_reg_wr,
    input  wire pipe_pkg::wr_sel_e exmem_wr_sel,
    input  wire pipe_pkg::word_t exmem_alu_result, // also the address
    input  wire pipe_pkg::word_t exmem_set_result,
    input  wire pipe_pkg::word_t exmem_lbi_result,
    input  wire pipe_pkg::word_t exmem_slbi_result,
    input  wire pipe_pkg::word_t exmem_store_data,
    // memory-to-memory forwarding
    input  wire                 mem_to_mem_fwd,
    input  wire pipe_pkg::word_t wb_data,
    // MEM/WB register
    output logic                memwb_reg_wr,
    output pipe_pkg::reg_idx_t  memwb_rd,
    output pipe_pkg::wr_sel_e   memwb_wr_sel,
    output logic                memwb_is_load,
    output pipe_pkg::word_t     memwb_alu_result,
    output pipe_pkg::word_t     memwb_mem_result,
    output pipe_pkg::word_t     memwb_set_result,
    output pipe_pkg::word_t     memwb_lbi_result,
    output pipe_pkg::word_t     memwb_slbi_result,
    // store report
    output logic                st_valid,
    output pipe_pkg::word_t     st_addr,
    output pipe_pkg::word_t     st_data
);

    localparam int ADDR_W = $clog2(`PIPE_DMEM_DEPTH);

    pipe_pkg::word_t dmem [`PIPE_DMEM_DEPTH]; // data memory
    logic [ADDR_W-1:0] addr;
    pipe_pkg::word_t store_data;
    logic do_store;

    assign addr       = exmem_alu_result[ADDR_W-1:0]; // wraps modulo depth
    assign store_data = mem_to_mem_fwd ? wb_data : exmem_store_data; // loaded value
    assign do_store   = exmem_valid && (exmem_op == pipe_pkg::OP_ST);

    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[addr] <= store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memwb_reg_wr  <= 1'b0;
            memwb_wr_sel  <= pipe_pkg::SEL_ALU;
            memwb_is_load <= 1'b0;
            st_valid      <= 1'b0;
        end else begin
            memwb_reg_wr  <= exmem_reg_wr;
            memwb_wr_sel  <= exmem_wr_sel;
            memwb_is_load <= exmem_valid && (exmem_op == pipe_pkg::OP_LD);
            st_valid      <= do_store; // one cycle per store
        end
    end

    always_ff @(posedge clk) begin
        memwb_rd          <= exmem_rd;
        memwb_alu_result  <= exmem_alu_result;
        memwb_mem_result  <= dmem[addr]; // load data
        memwb_set_result  <= exmem_set_result;
        memwb_lbi_result  <= exmem_lbi_result;
        memwb_slbi_result <= exmem_slbi_result;
        st_addr           <= exmem_alu_result;
        st_data           <= store_data;
    end

endmodule

`default_nettype wire

// File: hw/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire pipe_pkg::op_e  in_op,
    input  wire pipe_pkg::reg_idx_t in_rd,
    input  wire pipe_pkg::reg_idx_t in_rs,
    input  wire pipe_pkg::reg_idx_t in_rt,
    input  wire pipe_pkg::word_t in_imm,
    output logic                wb_valid,
    output pipe_pkg::reg_idx_t  wb_rd,
    output pipe_pkg::word_t     wb_data,
    output logic                st_valid,
    output pipe_pkg::word_t     st_addr,
    output pipe_pkg::word_t     st_data
);

    // ID/EX
    logic               idex_valid;
    pipe_pkg::op_e      idex_op;
    pipe_pkg::reg_idx_t idex_rd;
    pipe_pkg::reg_idx_t idex_rs;
    pipe_pkg::reg_idx_t idex_rt;
    logic               idex_has_rt;
    pipe_pkg::word_t    idex_imm;
    pipe_pkg::wr_sel_e  idex_wr_sel;
    logic               idex_reg_wr;
    pipe_pkg::word_t    idex_rs_val;
    pipe_pkg::word_t    idex_rt_val;
    // EX/MEM
    logic               exmem_valid;
    pipe_pkg::op_e      exmem_op;
    pipe_pkg::reg_idx_t exmem_rd;
    pipe_pkg::reg_idx_t exmem_rs;
    logic               exmem_reg_wr;
    pipe_pkg::wr_sel_e  exmem_wr_sel;
    pipe_pkg::word_t    exmem_alu_result;
    pipe_pkg::word_t    exmem_set_result;
    pipe_pkg::word_t    exmem_lbi_result;
    pipe_pkg::word_t    exmem_slbi_result;
    pipe_pkg::word_t    exmem_store_data;
    // MEM/WB
    logic               memwb_reg_wr;
    pipe_pkg::reg_idx_t memwb_rd;
    pipe_pkg::wr_sel_e  memwb_wr_sel;
    logic               memwb_is_load;
    pipe_pkg::word_t    memwb_alu_result;
    pipe_pkg::word_t    memwb_mem_result;
    pipe_pkg::word_t    memwb_set_result;
    pipe_pkg::word_t    memwb_lbi_result;
    pipe_pkg::word_t    memwb_slbi_result;
    // forwarding selects and values
    logic               ex_fwd_rs;
    logic               ex_fwd_rt;
    logic               mem_fwd_rs;
    logic               mem_fwd_rt;
    logic               mem_to_mem_fwd;
    pipe_pkg::word_t    ex_fwd_data;
    pipe_pkg::word_t    mem_fwd_data;

    assign wb_valid = memwb_reg_wr; // one cycle per writing op
    assign wb_rd    = memwb_rd;

    // all stage signals share names across blocks
    operand_fetch u_operand_fetch (.*);
    forward       u_forward       (.*);
    exec_stage    u_exec_stage    (.*);
    mem_stage     u_mem_stage     (.*);

endmodule

`default_nettype wire

// File: verification/pipe_ref_model.svh
`ifndef PIPE_REF_MODEL_SVH
`define PIPE_REF_MODEL_SVH

// shadow state, updated in acceptance order
pipe_pkg::word_t shadow_rf  [`PIPE_NUM_REGS];
pipe_pkg::word_t shadow_mem [`PIPE_DMEM_DEPTH];

// expected records {is_store, due cycle, rd or address, data}, at most one per cycle
logic [64:0] exp_q [$];

function automatic bit reads_rs(input pipe_pkg::op_e op);
    case (op)
        pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_XOR, pipe_pkg::OP_ANDN,
        pipe_pkg::OP_ADDI, pipe_pkg::OP_SEQ, pipe_pkg::OP_SLT, pipe_pkg::OP_SLBI,
        pipe_pkg::OP_ST: return 1'b1;
        default:         return 1'b0;
    endcase
endfunction

function automatic bit reads_rt(input pipe_pkg::op_e op);
    case (op)
        pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_XOR, pipe_pkg::OP_ANDN,
        pipe_pkg::OP_SEQ, pipe_pkg::OP_SLT, pipe_pkg::OP_LD,
        pipe_pkg::OP_ST: return 1'b1;
        default:         return 1'b0;
    endcase
endfunction

// a load right ahead of a reader costs one cycle, store data excepted
function automatic bit needs_bubble(input pipe_pkg::op_e prev_op, input pipe_pkg::reg_idx_t prev_rd,
                                    input pipe_pkg::op_e op, input pipe_pkg::reg_idx_t rs,
                                    input pipe_pkg::reg_idx_t rt);
    if (prev_op != pipe_pkg::OP_LD) begin
        return 1'b0;
    end
    return (reads_rt(op) && (rt == prev_rd)) ||
           (reads_rs(op) && (op != pipe_pkg::OP_ST) && (rs == prev_rd));
endfunction

task automatic model_accept(input pipe_pkg::op_e op, input pipe_pkg::reg_idx_t rd,
                            input pipe_pkg::reg_idx_t rs, input pipe_pkg::reg_idx_t rt,
                            input pipe_pkg::word_t imm, input int due);
    pipe_pkg::word_t a;
    pipe_pkg::word_t b;
    pipe_pkg::word_t addr;
    pipe_pkg::word_t res;
    bit writes;
    a      = shadow_rf[rs];
    b      = shadow_rf[rt];
    addr   = b + imm; // load and store address
    res    = '0;
    writes = 1'b1;
    case (op)
        pipe_pkg::OP_ADD:  res = a + b;
        pipe_pkg::OP_SUB:  res = a - b;
        pipe_pkg::OP_XOR:  res = a ^ b;
        pipe_pkg::OP_ANDN: res = a & ~b;
        pipe_pkg::OP_ADDI: res = a + imm;
        pipe_pkg::OP_SEQ:  res = (a == b) ? 16'd1 : 16'd0;
        pipe_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        pipe_pkg::OP_LBI:  res = imm;
        pipe_pkg::OP_SLBI: res = (a << 8) | (imm & 16'h00ff);
        pipe_pkg::OP_LD:   res = shadow_mem[addr % `PIPE_DMEM_DEPTH];
        pipe_pkg::OP_ST: begin
            shadow_mem[addr % `PIPE_DMEM_DEPTH] = a;
            exp_q.push_back({1'b1, due, addr, a});
            writes = 1'b0;
        end
        default: writes = 1'b0; // nop
    endcase
    if (writes) begin
        shadow_rf[rd] = res;
        exp_q.push_back({1'b0, due, 13'd0, rd, res});
    end
endtask

`endif

// File: verification/pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module pipe_tb;

    localparam int NUM_INIT     = `PIPE_NUM_REGS + 2 * `PIPE_DMEM_DEPTH;
    localparam int NUM_DIRECTED = 28;
    localparam int NUM_RANDOM   = 300;
    localparam int NUM_OPS      = NUM_INIT + NUM_DIRECTED + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = 4 * NUM_OPS + 100;

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    pipe_pkg::op_e      in_op;
    pipe_pkg::reg_idx_t in_rd;
    pipe_pkg::reg_idx_t in_rs;
    pipe_pkg::reg_idx_t in_rt;
    pipe_pkg::word_t    in_imm;
    logic               wb_valid;
    pipe_pkg::reg_idx_t wb_rd;
    pipe_pkg::word_t    wb_data;
    logic               st_valid;
    pipe_pkg::word_t    st_addr;
    pipe_pkg::word_t    st_data;

    int cyc = 0;      // rising edges so far
    logic [31:0] lfsr_state = 32'hd598;
    pipe_pkg::op_e      last_op = pipe_pkg::OP_NOP; // last accepted op
    pipe_pkg::reg_idx_t last_rd = '0;
    int last_edge = -10;

    `include "pipe_ref_model.svh"

    pipe_top u_dut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_rd(in_rd), .in_rs(in_rs), .in_rt(in_rt), .in_imm(in_imm),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "first error reached");
    endtask

    // galois lfsr, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic out;
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            out        = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
            val        = {val[14:0], out};
        end
        return val;
    endfunction

    // called just after a rising edge, returns after the accepting edge
    task automatic send_op(input pipe_pkg::op_e op, input pipe_pkg::reg_idx_t rd,
                           input pipe_pkg::reg_idx_t rs, input pipe_pkg::reg_idx_t rt,
                           input pipe_pkg::word_t imm);
        int stalls;
        bit exp_bubble;
        stalls     = 0;
        in_valid  <= 1'b1;
        in_op     <= op;
        in_rd     <= rd;
        in_rs     <= rs;
        in_rt     <= rt;
        in_imm    <= imm;
        @(negedge clk);
        exp_bubble = needs_bubble(last_op, last_rd, op, rs, rt) && (last_edge == cyc);
        while (!in_ready) begin
            stalls++; // held op waits
            @(posedge clk);
            @(negedge clk);
        end
        assert (stalls == int'(exp_bubble)) else
            stop_run($sformatf("CHECK FAILED at %0t: in_ready low %0d cycles, expected %0d",
                               $time, stalls, int'(exp_bubble)));
        model_accept(op, rd, rs, rt, imm, cyc + 3); // result due 3 edges on
        last_op   = op;
        last_rd   = rd;
        last_edge = cyc + 1;
        @(posedge clk);
    endtask

    // every register, then every memory word, gets a known value
    task automatic init_state();
        int r;
        int a;
        for (r = 0; r < `PIPE_NUM_REGS; r++) begin
            send_op(pipe_pkg::OP_LBI, 3'(r), 3'd0, 3'd0, rand_bits(16));
        end
        for (a = 0; a < `PIPE_DMEM_DEPTH; a++) begin
            send_op(pipe_pkg::OP_LBI, 3'd1, 3'd0, 3'd0, rand_bits(16));
            send_op(pipe_pkg::OP_ST, 3'd0, 3'd1, 3'd0, 16'(a) - shadow_rf[0]);
        end
    endtask

    task automatic directed_ops();
        // back-to-back on rs, rt and both
        send_op(pipe_pkg::OP_ADD,  3'd1, 3'd2, 3'd3, 16'h0000);
        send_op(pipe_pkg::OP_XOR,  3'd2, 3'd1, 3'd5, 16'h0000);
        send_op(pipe_pkg::OP_ANDN, 3'd3, 3'd6, 3'd2, 16'h0000);
        send_op(pipe_pkg::OP_ADD,  3'd4, 3'd3, 3'd3, 16'h0000);
        // two apart, then r1 pending in both stages
        send_op(pipe_pkg::OP_ADDI, 3'd5, 3'd4, 3'd0, 16'h0123);
        send_op(pipe_pkg::OP_NOP,  3'd0, 3'd0, 3'd0, 16'h0000);
        send_op(pipe_pkg::OP_SLT,  3'd6, 3'd5, 3'd0, 16'h0000);
        send_op(pipe_pkg::OP_ADDI, 3'd1, 3'd1, 3'd0, 16'h0011);
        send_op(pipe_pkg::OP_ADDI, 3'd1, 3'd1, 3'd0, 16'h0200);
        send_op(pipe_pkg::OP_ADD,  3'd7, 3'd1, 3'd1, 16'h0000); // younger r1 wins
        // load-use on rs and on rt
        send_op(pipe_pkg::OP_LD,   3'd2, 3'd0, 3'd3, 16'h0004);
        send_op(pipe_pkg::OP_ADD,  3'd4, 3'd2, 3'd1, 16'h0000);
        send_op(pipe_pkg::OP_LD,   3'd5, 3'd0, 3'd0, 16'h0007);
        send_op(pipe_pkg::OP_LD,   3'd6, 3'd0, 3'd5, 16'h0000);
        // store of a just-loaded register, no bubble
        send_op(pipe_pkg::OP_LD,   3'd3, 3'd0, 3'd0, 16'h0009);
        send_op(pipe_pkg::OP_ST,   3'd0, 3'd3, 3'd1, 16'h0002);
        // set, lbi and slbi results through both stages
        send_op(pipe_pkg::OP_SEQ,  3'd1, 3'd2, 3'd2, 16'h0000);
        send_op(pipe_pkg::OP_ADD,  3'd3, 3'd1, 3'd1, 16'h0000);
        send_op(pipe_pkg::OP_LBI,  3'd4, 3'd0, 3'd0, 16'hff85);
        send_op(pipe_pkg::OP_SLBI, 3'd5, 3'd4, 3'd0, 16'h00a7);
        send_op(pipe_pkg::OP_ADD,  3'd6, 3'd5, 3'd4, 16'h0000);
        send_op(pipe_pkg::OP_SLT,  3'd7, 3'd6, 3'd3, 16'h0000);
        send_op(pipe_pkg::OP_NOP,  3'd0, 3'd0, 3'd0, 16'h0000);
        send_op(pipe_pkg::OP_SUB,  3'd0, 3'd7, 3'd6, 16'h0000);
        send_op(pipe_pkg::OP_SLBI, 3'd2, 3'd0, 3'd0, 16'h0011);
        send_op(pipe_pkg::OP_NOP,  3'd0, 3'd0, 3'd0, 16'h0000);
        send_op(pipe_pkg::OP_ADD,  3'd3, 3'd2, 3'd2, 16'h0000);
        send_op(pipe_pkg::OP_XOR,  3'd4, 3'd3, 3'd0, 16'h0000);
    endtask

    task automatic random_ops(input int n);
        int k;
        int code;
        pipe_pkg::reg_idx_t rd;
        pipe_pkg::reg_idx_t rs;
        pipe_pkg::reg_idx_t rt;
        pipe_pkg::word_t imm;
        for (k = 0; k < n; k++) begin
            code = int'(rand_bits(4)) % 12; // all twelve ops
            rd   = 3'(rand_bits(3));
            rs   = 3'(rand_bits(3));
            rt   = 3'(rand_bits(3));
            imm  = rand_bits(16);
            send_op(pipe_pkg::op_e'(code), rd, rs, rt, imm);
        end
    endtask

    // outputs checked mid-cycle against the oldest expected record
    always @(negedge clk) begin
        logic [64:0] head;
        logic due_now;
        if (!rst) begin
            due_now = 1'b0;
            head    = '0;
            if ((exp_q.size() > 0) && (exp_q[0][63:32] == cyc)) begin
                due_now = 1'b1;
                head    = exp_q.pop_front();
            end
            assert (wb_valid === (due_now && !head[64])) else
                stop_run($sformatf("write-back valid was %b at %0t, not 3 cycles after its op",
                                   wb_valid, $time));
            assert (st_valid === (due_now && head[64])) else
                stop_run($sformatf("store valid was %b at %0t, not 3 cycles after its op",
                                   st_valid, $time));
            if (due_now && !head[64]) begin
                assert ((wb_rd === head[18:16]) && (wb_data === head[15:0])) else
                    stop_run($sformatf("CHECK FAILED at %0t: write-back r%0d=%h, expected r%0d=%h",
                                       $time, wb_rd, wb_data, head[18:16], head[15:0]));
            end
            if (due_now && head[64]) begin
                assert ((st_addr === head[31:16]) && (st_data === head[15:0])) else
                    stop_run($sformatf("CHECK FAILED at %0t: store [%h]=%h, expected [%h]=%h",
                                       $time, st_addr, st_data, head[31:16], head[15:0]));
            end
        end
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = pipe_pkg::OP_NOP;
        in_rd    = '0;
        in_rs    = '0;
        in_rt    = '0;
        in_imm   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!wb_valid && !st_valid && in_ready) else
            stop_run($sformatf("CHECK FAILED at %0t: idle state after reset is wrong", $time));
        @(posedge clk);
        init_state();
        directed_ops();
        random_ops(NUM_RANDOM);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // quiet tail, spurious outputs still flagged
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
+incdir+verification
common/pipe_pkg.sv
hw/operand_fetch/operand_fetch.sv
hw/forward/forward.sv
hw/execute/exec_stage.sv
hw/mem_stage/mem_stage.sv
hw/pipe_top.sv
verification/pipe_tb.sv

// File: Bender.yml
package:
  name: pipe_backend

export_include_dirs:
  - common

sources:
  - common/pipe_pkg.sv
  - hw/operand_fetch/operand_fetch.sv
  - hw/forward/forward.sv
  - hw/execute/exec_stage.sv
  - hw/mem_stage/mem_stage.sv
  - hw/pipe_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/pipe_tb.sv
